//--- zx81_bus.f
verilog/zx81_pkg.sv
verilog/cpu_bus_if.sv
verilog/machine_config.sv
verilog/memory_map.sv
verilog/joystick_zxpand.sv
verilog/io_ports.sv
verilog/data_bus_mux.sv
verilog/zx81_bus.sv
test/tb_zx81_bus.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_zx81_bus
FILELIST ?= zx81_bus.f
BUILD_DIR ?= obj_dir
JOBS ?= 0
VFLAGS ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing -Wall

SOURCES := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- test/tb_zx81_bus.sv
// Directed tests of zx81_bus; the reconfiguration test alone runs about 1M clocks of 40 ns
`timescale 1ns/1ps

module tb_zx81_bus;

	localparam longint WATCHDOG_NS = (longint'(zx81_pkg::RECONFIG_HOLD) + 20000) * 40;

	// Strobe sets {mreq_n, iorq_n, rd_n, wr_n, m1_n, halt_n}
	localparam logic [5:0] CYC_IDLE = 6'b111111;
	localparam logic [5:0] CYC_MEM_RD = 6'b010111;
	localparam logic [5:0] CYC_MEM_WR = 6'b011011;
	localparam logic [5:0] CYC_M1 = 6'b010101;
	localparam logic [5:0] CYC_M1_HALT = 6'b010100;
	localparam logic [5:0] CYC_IO_RD = 6'b100111;
	localparam logic [5:0] CYC_IO_WR = 6'b101011;
	localparam logic [5:0] CYC_INTA = 6'b101101;

	logic clk_sys;
	logic reset;
	zx81_pkg::addr_t addr;
	zx81_pkg::byte_t dout;
	logic mreq_n, iorq_n, rd_n, wr_n, m1_n, halt_n;
	logic cfg_zx80;
	zx81_pkg::mem_size_e cfg_ram;
	logic low_ram_en;
	logic chroma_en;
	logic hz50;
	logic [1:0] joy_mode;
	zx81_pkg::joy_t joy_0;
	zx81_pkg::joy_t joy_1;
	zx81_pkg::key_row_t key_rows;
	zx81_pkg::byte_t rom_data;
	zx81_pkg::byte_t ram_data;
	zx81_pkg::byte_t chroma_data;
	zx81_pkg::byte_t cpu_din;
	logic machine_reset;
	logic zx81;
	logic rom_cs;
	logic ram_cs;
	logic chroma_cs;
	zx81_pkg::rom_addr_t rom_addr;
	zx81_pkg::ram_addr_t ram_addr;
	logic ram_we;
	logic chroma_we;
	zx81_pkg::byte_t chroma_mode;
	logic [31:0] lfsr;

	zx81_bus u_dut (.*);

	// ==============================
	// Memory models
	// ==============================
	function automatic zx81_pkg::byte_t rom_model(input zx81_pkg::rom_addr_t a);
		return a[7:0] ^ {a[13:8], 2'b10};
	endfunction

	function automatic zx81_pkg::byte_t ram_model(input zx81_pkg::ram_addr_t a);
		return a[7:0] ^ a[15:8] ^ 8'h3C;
	endfunction

	function automatic zx81_pkg::byte_t colour_model(input zx81_pkg::addr_t a);
		return ~(a[7:0] ^ {a[14:8], a[15]});
	endfunction

	assign rom_data = rom_model(rom_addr);
	assign ram_data = ram_model(ram_addr);
	assign chroma_data = colour_model(addr);

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'hD000_0001 : 32'h0);
		end
		return r;
	endfunction

	// ==============================
	// Expected values
	// ==============================
	function automatic logic big_mem(input zx81_pkg::mem_size_e size);
		return size == zx81_pkg::MEM_32K || size == zx81_pkg::MEM_48K;
	endfunction

	// Below 32K the top half mirrors the bottom half
	function automatic logic low_half(input zx81_pkg::addr_t a, input zx81_pkg::mem_size_e size);
		return !a[15] || !big_mem(size);
	endfunction

	function automatic logic rom_select(input zx81_pkg::addr_t a,
		input zx81_pkg::mem_size_e size, input logic is_zx81);
		return a[14:13] == 2'b00 && (is_zx81 || !a[12]) && low_half(a, size);
	endfunction

	function automatic logic ram_select(input zx81_pkg::addr_t a,
		input zx81_pkg::mem_size_e size, input logic low_en);
		return a[14] || (a[15] && big_mem(size))
			|| (low_en && a[14:13] == 2'b01 && low_half(a, size));
	endfunction

	function automatic zx81_pkg::rom_addr_t rom_address(input zx81_pkg::addr_t a,
		input logic is_zx81);
		return is_zx81 ? {1'b0, a[12:0]} : 14'h2000 + {2'b00, a[11:0]};
	endfunction

	function automatic zx81_pkg::ram_addr_t ram_address(input zx81_pkg::addr_t a,
		input zx81_pkg::mem_size_e size, input logic m1_high);
		if (a[14:13] == 2'b01 && low_half(a, size)) begin
			return 16'h2000 + {3'b000, a[12:0]};
		end
		if (size == zx81_pkg::MEM_1K) begin
			return 16'h4000 + {6'b000000, a[9:0]};
		end
		if (big_mem(size) && a[15:14] == 2'b10) begin
			return 16'h8000 + {2'b00, a[13:0]};
		end
		if (size == zx81_pkg::MEM_48K && a[15:14] == 2'b11 && m1_high) begin
			return 16'hC000 + {2'b00, a[13:0]};
		end
		return 16'h4000 + {2'b00, a[13:0]};
	endfunction

	function automatic zx81_pkg::byte_t memory_byte(input zx81_pkg::addr_t a,
		input zx81_pkg::mem_size_e size, input logic m1_high);
		if (chroma_en && m1_high && a[15:14] == 2'b11) begin
			return colour_model(a);
		end else if (rom_select(a, size, 1'b1)) begin
			return rom_model(rom_address(a, 1'b1));
		end else if (ram_select(a, size, low_ram_en)) begin
			return ram_model(ram_address(a, size, m1_high));
		end
		return 8'hFF;
	endfunction

	function automatic zx81_pkg::key_row_t joystick_keys(input zx81_pkg::joy_t j,
		input logic [1:0] mode, input logic a12, input logic a11);
		zx81_pkg::key_row_t mask_a;
		zx81_pkg::key_row_t mask_b;
		mask_a = '0;
		mask_b = '0;
		if (mode[0]) begin
			mask_a = mask_a | {j[1], j[0], j[2], j[3], j[4]};
		end
		if (mode[1]) begin
			mask_a = mask_a | {j[2], j[3], j[0], j[1], j[4]};
		end
		if (mode == 2'b00) begin
			mask_a = {j[2], j[3], j[0], 1'b0, j[4]};
			mask_b = {j[1], 4'b0000};
		end
		return ~((a12 ? 5'b00000 : mask_a) | (a11 ? 5'b00000 : mask_b));
	endfunction

	// ==============================
	// Compare tasks
	// ==============================
	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic check_byte(input string name, input zx81_pkg::byte_t act,
		input zx81_pkg::byte_t exp);
		if (act !== exp) begin
			fail_run($sformatf("FAIL %s got %h expected %h", name, act, exp));
		end
	endtask

	task automatic check_ram_addr(input string name, input zx81_pkg::ram_addr_t act,
		input zx81_pkg::ram_addr_t exp);
		if (act !== exp) begin
			fail_run($sformatf("FAIL %s got %h expected %h", name, act, exp));
		end
	endtask

	task automatic check_rom_addr(input string name, input zx81_pkg::rom_addr_t act,
		input zx81_pkg::rom_addr_t exp);
		if (act !== exp) begin
			fail_run($sformatf("FAIL %s got %h expected %h", name, act, exp));
		end
	endtask

	task automatic check_bit(input string name, input logic act, input logic exp);
		if (act !== exp) begin
			fail_run($sformatf("FAIL %s got %h expected %h", name, act, exp));
		end
	endtask

	task automatic check_keys(input string name, input zx81_pkg::key_row_t act,
		input zx81_pkg::key_row_t exp);
		if (act !== exp) begin
			fail_run($sformatf("FAIL %s got %h expected %h", name, act, exp));
		end
	endtask

	// ==============================
	// Bus drivers
	// ==============================
	task automatic drive_bus(input zx81_pkg::addr_t a, input zx81_pkg::byte_t d,
		input logic [5:0] strobes);
		@(posedge clk_sys);
		addr <= a;
		dout <= d;
		{mreq_n, iorq_n, rd_n, wr_n, m1_n, halt_n} <= strobes;
		@(negedge clk_sys);
	endtask

	// Configuration inputs are latched while reset holds the machine
	task automatic apply_reset(input zx81_pkg::mem_size_e size, input logic zx80);
		@(posedge clk_sys);
		reset <= 1'b1;
		cfg_ram <= size;
		cfg_zx80 <= zx80;
		{mreq_n, iorq_n, rd_n, wr_n, m1_n, halt_n} <= CYC_IDLE;
		repeat (16) @(posedge clk_sys);
		reset <= 1'b0;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		check_bit("machine_reset", machine_reset, 1'b0);
		check_bit("zx81", zx81, ~zx80);
	endtask

	task automatic check_map(input zx81_pkg::addr_t a, input zx81_pkg::mem_size_e size,
		input logic is_zx81);
		logic rom_exp;
		logic ram_exp;
		rom_exp = rom_select(a, size, is_zx81);
		ram_exp = ram_select(a, size, low_ram_en);
		for (int m1 = 0; m1 < 2; m1++) begin
			drive_bus(a, 8'h00, (m1 == 1) ? CYC_MEM_RD : CYC_M1);
			check_bit("rom_cs", rom_cs, rom_exp);
			check_bit("ram_cs", ram_cs, ram_exp);
			check_bit("ram_we", ram_we, 1'b0);
			if (rom_exp) begin
				check_rom_addr("rom_addr", rom_addr, rom_address(a, is_zx81));
			end
			if (ram_exp) begin
				check_ram_addr("ram_addr", ram_addr, ram_address(a, size, m1 == 1));
			end
		end
		drive_bus(a, 8'(rand_bits(8)), CYC_MEM_WR);
		check_bit("ram_we", ram_we, ram_exp);
	endtask

	task automatic sweep_map(input zx81_pkg::mem_size_e size, input logic is_zx81, input int n);
		for (int low = 0; low < 2; low++) begin
			@(posedge clk_sys);
			low_ram_en <= (low == 1);
			// Every 8K region gets visited
			for (int i = 0; i < n; i++) begin
				check_map({3'(i), 13'(rand_bits(13))}, size, is_zx81);
			end
		end
	endtask

	task automatic check_keyboard(input zx81_pkg::addr_t a, input zx81_pkg::key_row_t keys);
		drive_bus(a, 8'h00, CYC_IO_RD);
		check_keys("key bits", zx81_pkg::key_row_t'(cpu_din[4:0]), key_rows & keys);
		check_byte("cpu_din", cpu_din, {1'b0, hz50, 1'b0, key_rows & keys});
	endtask

	task automatic zxpand_command(input zx81_pkg::byte_t cmd, input zx81_pkg::byte_t exp);
		drive_bus(zx81_pkg::ZXPAND_PORT, cmd, CYC_IO_WR);
		drive_bus(zx81_pkg::ZXPAND_PORT, 8'h00, CYC_IO_RD);
		check_byte("zxp_data", cpu_din, exp);
	endtask

	// ==============================
	// Tests
	// ==============================
	task automatic memory_map_test();
		for (int s = 0; s < 4; s++) begin
			for (int z = 0; z < 2; z++) begin
				apply_reset(zx81_pkg::mem_size_e'(2'(s)), z == 1);
				sweep_map(zx81_pkg::mem_size_e'(2'(s)), z == 0, 24);
			end
		end
	endtask

	task automatic read_mux_test();
		zx81_pkg::addr_t a;
		zx81_pkg::mem_size_e size;
		zx81_pkg::byte_t mem;
		logic halt;
		for (int s = 0; s < 2; s++) begin
			size = (s == 0) ? zx81_pkg::MEM_1K : zx81_pkg::MEM_48K;
			apply_reset(size, 1'b0);
			for (int n = 0; n < 32; n++) begin
				a = 16'(rand_bits(16));
				halt = 1'(rand_bits(1));
				@(posedge clk_sys);
				low_ram_en <= 1'(rand_bits(1));
				chroma_en <= 1'(rand_bits(1));
				drive_bus(a, 8'h00, CYC_MEM_RD);
				check_byte("cpu_din", cpu_din, memory_byte(a, size, 1'b1));
				drive_bus(a, 8'h00, halt ? CYC_M1 : CYC_M1_HALT);
				mem = memory_byte(a, size, 1'b0);
				// Display file characters come back as NOP
				if (a[15] && !mem[6] && halt) begin
					mem = 8'h00;
				end
				check_byte("cpu_din", cpu_din, mem);
				a[0] = 1'b1;
				if (a == zx81_pkg::CHROMA_PORT) begin
					a[1] = 1'b0;
				end
				drive_bus(a, 8'h00, CYC_IO_RD);
				check_byte("cpu_din", cpu_din, 8'hFF);
				drive_bus(a, 8'h00, CYC_INTA);
				check_byte("cpu_din", cpu_din, 8'hFF);
				drive_bus(a, 8'h00, CYC_IDLE);
				check_byte("cpu_din", cpu_din, 8'hFF);
			end
		end
	endtask

	task automatic keyboard_test();
		zx81_pkg::joy_t joy;
		zx81_pkg::addr_t a;
		for (int mode = 0; mode < 4; mode++) begin
			for (int dir = 0; dir < 5; dir++) begin
				for (int sel = 0; sel < 4; sel++) begin
					joy = 5'b00001 << dir;
					a = {3'(rand_bits(3)), sel[1], sel[0], 10'(rand_bits(10)), 1'b0};
					@(posedge clk_sys);
					joy_mode <= 2'(mode);
					hz50 <= 1'(rand_bits(1));
					key_rows <= 5'(rand_bits(5));
					joy_0 <= sel[0] ? joy : 5'b00000;
					joy_1 <= sel[0] ? 5'b00000 : joy;
					check_keyboard(a, joystick_keys(joy, 2'(mode), a[12], a[11]));
				end
			end
		end
	endtask

	task automatic zxpand_test();
		zx81_pkg::joy_t joy;
		// Up and fire held
		joy = 5'b11000;
		@(posedge clk_sys);
		joy_0 <= joy;
		joy_1 <= 5'b00000;
		joy_mode <= 2'b00;
		key_rows <= 5'b11111;
		check_keyboard(16'hEFFE, joystick_keys(joy, 2'b00, 1'b0, 1'b1));
		zxpand_command(8'hAA, 8'hF0);
		zxpand_command(8'h55, 8'h0F);
		zxpand_command(8'h3C, 8'hFF);
		zxpand_command(8'hA0, {~joy[3], ~joy[2], ~joy[1], ~joy[0], ~joy[4], 3'b000});
		check_keyboard(16'hEFFE, 5'b11111);
		apply_reset(zx81_pkg::MEM_48K, 1'b0);
		drive_bus(zx81_pkg::ZXPAND_PORT, 8'h00, CYC_IO_RD);
		check_byte("zxp_data", cpu_din, 8'hFF);
		check_keyboard(16'hEFFE, joystick_keys(joy, 2'b00, 1'b0, 1'b1));
	endtask

	task automatic chroma_test();
		zx81_pkg::byte_t mode;
		zx81_pkg::addr_t a;
		mode = 8'(rand_bits(8)) | 8'h01;
		a = {2'b11, 14'(rand_bits(14))};
		@(posedge clk_sys);
		chroma_en <= 1'b0;
		drive_bus(zx81_pkg::CHROMA_PORT, 8'h00, CYC_IO_RD);
		check_byte("cpu_din", cpu_din, 8'hFF);
		@(posedge clk_sys);
		chroma_en <= 1'b1;
		drive_bus(zx81_pkg::CHROMA_PORT, 8'h00, CYC_IO_RD);
		check_byte("cpu_din", cpu_din, 8'hDF);
		drive_bus(zx81_pkg::CHROMA_PORT, mode, CYC_IO_WR);
		drive_bus(16'h0000, 8'h00, CYC_IDLE);
		check_byte("chroma_mode", chroma_mode, mode);
		drive_bus(a, 8'h5A, CYC_MEM_WR);
		check_bit("chroma_cs", chroma_cs, 1'b1);
		check_bit("chroma_we", chroma_we, 1'b1);
		check_bit("ram_we", ram_we, 1'b0);
		drive_bus(a, 8'h00, CYC_M1);
		check_bit("chroma_cs", chroma_cs, 1'b0);
		check_bit("chroma_we", chroma_we, 1'b0);
		@(posedge clk_sys);
		chroma_en <= 1'b0;
		drive_bus(a, 8'h5A, CYC_MEM_WR);
		check_byte("chroma_mode", chroma_mode, 8'h00);
		check_bit("chroma_cs", chroma_cs, 1'b0);
		check_bit("chroma_we", chroma_we, 1'b0);
		check_bit("ram_we", ram_we, 1'b1);
	endtask

	task automatic reconfig_test();
		int rise;
		int fall;
		apply_reset(zx81_pkg::MEM_16K, 1'b0);
		@(posedge clk_sys);
		cfg_ram <= zx81_pkg::MEM_48K;
		rise = 0;
		@(negedge clk_sys);
		while (!machine_reset && rise < 3) begin
			@(negedge clk_sys);
			rise++;
		end
		if (!machine_reset || rise > 2) begin
			fail_run("machine_reset did not rise within 2 cycles of the RAM size change");
		end
		fall = 0;
		while (machine_reset && fall <= int'(zx81_pkg::RECONFIG_HOLD) + 4) begin
			@(negedge clk_sys);
			fall++;
		end
		if (fall < int'(zx81_pkg::RECONFIG_HOLD) || fall > int'(zx81_pkg::RECONFIG_HOLD) + 4) begin
			fail_run($sformatf("machine_reset fell %0d cycles after rising, outside the hold window",
				fall));
		end
		sweep_map(zx81_pkg::MEM_48K, 1'b1, 16);
	endtask

	// ==============================
	// Clock, watchdog, sequence
	// ==============================
	initial begin
		clk_sys = 1'b0;
		forever begin
			#20 clk_sys = ~clk_sys;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		fail_run("Watchdog expired before the tests finished");
	end

	initial begin
		lfsr = 32'ha95d_2a1d;
		reset = 1'b1;
		addr = '0;
		dout = '0;
		{mreq_n, iorq_n, rd_n, wr_n, m1_n, halt_n} = CYC_IDLE;
		cfg_zx80 = 1'b0;
		cfg_ram = zx81_pkg::MEM_16K;
		low_ram_en = 1'b0;
		chroma_en = 1'b0;
		hz50 = 1'b0;
		joy_mode = 2'b00;
		joy_0 = '0;
		joy_1 = '0;
		key_rows = '1;
		apply_reset(zx81_pkg::MEM_16K, 1'b0);
		memory_map_test();
		read_mux_test();
		keyboard_test();
		zxpand_test();
		chroma_test();
		reconfig_test();
		$display("All tests passed");
		$finish;
	end

endmodule

//--- verilog/zx81_bus.sv
// CPU-side glue of the ZX81/ZX80; CPU, ROM, RAM and colour RAM are external and read async
`timescale 1ns/1ps

module zx81_bus (
	input  logic                clk_sys,
	input  logic                reset,
	input  zx81_pkg::addr_t     addr,
	input  zx81_pkg::byte_t     dout,
	input  logic                mreq_n,
	input  logic                iorq_n,
	input  logic                rd_n,
	input  logic                wr_n,
	input  logic                m1_n,
	input  logic                halt_n,
	input  logic                cfg_zx80,
	input  zx81_pkg::mem_size_e cfg_ram,
	input  logic                low_ram_en,
	input  logic                chroma_en,
	input  logic                hz50,
	input  logic [1:0]          joy_mode,
	input  zx81_pkg::joy_t      joy_0,
	input  zx81_pkg::joy_t      joy_1,
	input  zx81_pkg::key_row_t  key_rows,
	input  zx81_pkg::byte_t     rom_data,
	input  zx81_pkg::byte_t     ram_data,
	input  zx81_pkg::byte_t     chroma_data,
	output zx81_pkg::byte_t     cpu_din,
	output logic                machine_reset,
	output logic                zx81,
	output logic                rom_cs,
	output logic                ram_cs,
	output logic                chroma_cs,
	output zx81_pkg::rom_addr_t rom_addr,
	output zx81_pkg::ram_addr_t ram_addr,
	output logic                ram_we,
	output logic                chroma_we,
	output zx81_pkg::byte_t     chroma_mode
);

	zx81_pkg::mem_size_e mem_size;
	zx81_pkg::key_row_t joy_keys;
	zx81_pkg::byte_t zxp_data;
	zx81_pkg::byte_t io_data;
	logic zxp_sel;

	cpu_bus_if bus ();

	assign bus.addr = addr;
	assign bus.dout = dout;
	assign bus.mreq_n = mreq_n;
	assign bus.iorq_n = iorq_n;
	assign bus.rd_n = rd_n;
	assign bus.wr_n = wr_n;
	assign bus.m1_n = m1_n;
	assign bus.halt_n = halt_n;

	machine_config u_config (
		.clk_sys(clk_sys),
		.reset(reset),
		.cfg_zx80(cfg_zx80),
		.cfg_ram(cfg_ram),
		.zx81(zx81),
		.mem_size(mem_size),
		.machine_reset(machine_reset)
	);

	memory_map u_memory_map (
		.bus(bus.decoder),
		.zx81(zx81),
		.mem_size(mem_size),
		.low_ram_en(low_ram_en),
		.chroma_en(chroma_en),
		.rom_cs(rom_cs),
		.ram_cs(ram_cs),
		.chroma_cs(chroma_cs),
		.rom_addr(rom_addr),
		.ram_addr(ram_addr),
		.ram_we(ram_we),
		.chroma_we(chroma_we)
	);

	joystick_zxpand u_joystick (
		.clk_sys(clk_sys),
		.machine_reset(machine_reset),
		.bus(bus.decoder),
		.joy_0(joy_0),
		.joy_1(joy_1),
		.joy_mode(joy_mode),
		.joy_keys(joy_keys),
		.zxp_data(zxp_data),
		.zxp_sel(zxp_sel)
	);

	io_ports u_io_ports (
		.clk_sys(clk_sys),
		.machine_reset(machine_reset),
		.bus(bus.decoder),
		.chroma_en(chroma_en),
		.hz50(hz50),
		.key_rows(key_rows),
		.joy_keys(joy_keys),
		.zxp_sel(zxp_sel),
		.zxp_data(zxp_data),
		.io_data(io_data),
		.chroma_mode(chroma_mode)
	);

	data_bus_mux u_data_mux (
		.bus(bus.decoder),
		.rom_cs(rom_cs),
		.ram_cs(ram_cs),
		.chroma_cs(chroma_cs),
		.rom_data(rom_data),
		.ram_data(ram_data),
		.chroma_data(chroma_data),
		.io_data(io_data),
		.cpu_din(cpu_din)
	);

endmodule

//--- verilog/data_bus_mux.sv
// CPU read data is combinational; the NOP generator assumes display code runs above 8000h
`timescale 1ns/1ps

module data_bus_mux (
	cpu_bus_if.decoder      bus,
	input  logic            rom_cs,
	input  logic            ram_cs,
	input  logic            chroma_cs,
	input  zx81_pkg::byte_t rom_data,
	input  zx81_pkg::byte_t ram_data,
	input  zx81_pkg::byte_t chroma_data,
	input  zx81_pkg::byte_t io_data,
	output zx81_pkg::byte_t cpu_din
);

	zx81_pkg::byte_t mem_byte;
	logic nop_gen;

	always_comb begin
		if (chroma_cs) begin
			mem_byte = chroma_data;
		end else if (rom_cs) begin
			mem_byte = rom_data;
		end else if (ram_cs) begin
			mem_byte = ram_data;
		end else begin
			mem_byte = zx81_pkg::BUS_FLOAT;
		end
	end

	// Characters (bit 6 clear) execute as NOP while the video hardware reads them
	assign nop_gen = ~bus.m1_n & bus.addr[15] & ~mem_byte[6] & bus.halt_n;

	// Second bit low only on a plain I/O read
	always_comb begin
		case ({bus.mreq_n, ~bus.m1_n | bus.iorq_n | bus.rd_n})
			2'b01: cpu_din = nop_gen ? zx81_pkg::Z80_NOP : mem_byte;
			2'b10: cpu_din = io_data;
			default: cpu_din = zx81_pkg::BUS_FLOAT;
		endcase
	end

endmodule

//--- verilog/io_ports.sv
// I/O read byte and CHROMA81 mode; tape input is not wired and reads as 0
`timescale 1ns/1ps

module io_ports (
	input  logic               clk_sys,
	input  logic               machine_reset,
	cpu_bus_if.decoder         bus,
	input  logic               chroma_en,
	input  logic               hz50,
	input  zx81_pkg::key_row_t key_rows,
	input  zx81_pkg::key_row_t joy_keys,
	input  logic               zxp_sel,
	input  zx81_pkg::byte_t    zxp_data,
	output zx81_pkg::byte_t    io_data,
	output zx81_pkg::byte_t    chroma_mode
);

	logic kbd_sel;
	logic chroma_sel;

	// Any even port reads the keyboard
	assign kbd_sel = ~bus.iorq_n & ~bus.rd_n & ~bus.addr[0];
	assign chroma_sel = chroma_en & ~bus.iorq_n & (bus.addr == zx81_pkg::CHROMA_PORT);

	always_comb begin
		if (kbd_sel) begin
			io_data = {1'b0, hz50, 1'b0, key_rows & joy_keys};
		end else if (zxp_sel) begin
			io_data = zxp_data;
		end else if (chroma_sel) begin
			// Lets software detect the colour board
			io_data = zx81_pkg::CHROMA_ID;
		end else begin
			io_data = zx81_pkg::BUS_FLOAT;
		end
	end

	// ==============================
	// CHROMA81 mode register
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (machine_reset || !chroma_en) begin
			chroma_mode <= '0;
		end else if (chroma_sel & ~bus.wr_n) begin
			chroma_mode <= bus.dout;
		end
	end

endmodule

//--- verilog/joystick_zxpand.sv
// Joysticks fold onto keyboard rows until ZXpand mode is armed by writing A0h to E007h
`timescale 1ns/1ps

module joystick_zxpand (
	input  logic               clk_sys,
	input  logic               machine_reset,
	cpu_bus_if.decoder         bus,
	input  zx81_pkg::joy_t     joy_0,
	input  zx81_pkg::joy_t     joy_1,
	input  logic [1:0]         joy_mode,
	output zx81_pkg::key_row_t joy_keys,
	output zx81_pkg::byte_t    zxp_data,
	output logic               zxp_sel
);

	zx81_pkg::joy_t joy;
	zx81_pkg::key_row_t mask_a;
	zx81_pkg::key_row_t mask_b;
	logic cursor;
	logic zxp_use;

	assign joy = joy_0 | joy_1;
	assign cursor = (joy_mode == 2'b00);

	// ==============================
	// Keyboard mapping
	// ==============================

	// Row A: Sinclair 1 on 67890, ZX81 and Cursor on 5678/0
	assign mask_a = ({5{joy_mode[0]}} & {joy[1], joy[0], joy[2], joy[3], joy[4]})
		| ({5{joy_mode[1]}} & {joy[2], joy[3], joy[0], joy[1], joy[4]})
		| ({5{cursor}} & {joy[2], joy[3], joy[0], 1'b0, joy[4]});

	// Cursor left is key 5, on the other half row
	assign mask_b = {cursor & joy[1], 4'b0000};

	assign joy_keys = zxp_use ? '1
		: ~((mask_a & {5{~bus.addr[12]}}) | (mask_b & {5{~bus.addr[11]}}));

	// ==============================
	// ZXpand port
	// ==============================
	assign zxp_sel = ~bus.iorq_n & (bus.addr == zx81_pkg::ZXPAND_PORT);

	always_ff @(posedge clk_sys) begin
		if (machine_reset) begin
			zxp_data <= 8'hFF;
			zxp_use <= 1'b0;
		end else if (zxp_sel & ~bus.wr_n) begin
			case (bus.dout)
				zx81_pkg::ZXP_CMD_HIGH: zxp_data <= 8'hF0;
				zx81_pkg::ZXP_CMD_LOW: zxp_data <= 8'h0F;
				zx81_pkg::ZXP_CMD_JOY: begin
					// Active low directions in the top nibble
					zxp_data <= {~joy[3:0], ~joy[4], 3'b000};
					zxp_use <= 1'b1;
				end
				default: zxp_data <= 8'hFF;
			endcase
		end
	end

endmodule

//--- verilog/memory_map.sv
// Address-only ROM/RAM decode with partial mirrors; colour RAM at C000h needs non-M1 cycles
`timescale 1ns/1ps

module memory_map (
	cpu_bus_if.decoder          bus,
	input  logic                zx81,
	input  zx81_pkg::mem_size_e mem_size,
	input  logic                low_ram_en,
	input  logic                chroma_en,
	output logic                rom_cs,
	output logic                ram_cs,
	output logic                chroma_cs,
	output zx81_pkg::rom_addr_t rom_addr,
	output zx81_pkg::ram_addr_t ram_addr,
	output logic                ram_we,
	output logic                chroma_we
);

	logic mem_big;
	logic mem_48k;
	logic low_half;
	logic ram_lo;
	logic ram_hi;
	logic mem_write;

	assign mem_big = (mem_size == zx81_pkg::MEM_32K) || (mem_size == zx81_pkg::MEM_48K);
	assign mem_48k = (mem_size == zx81_pkg::MEM_48K);

	// Below 32K the upper half just mirrors the lower half
	assign low_half = ~bus.addr[15] | ~mem_big;

	// ==============================
	// Chip selects
	// ==============================
	assign ram_lo = ~bus.addr[14] & bus.addr[13] & low_half;
	// 8000h-BFFFh on 32K and 48K
	assign ram_hi = bus.addr[15] & ~bus.addr[14] & mem_big;

	assign ram_cs = bus.addr[14] | ram_hi | (ram_lo & low_ram_en);
	// ZX80 ROM is only 4K
	assign rom_cs = ~bus.addr[14] & ~bus.addr[13] & (~bus.addr[12] | zx81) & low_half;

	// Colour RAM overlays the top 16K for data accesses only
	assign chroma_cs = chroma_en & ~bus.mreq_n & bus.m1_n & bus.addr[15] & bus.addr[14];

	// ==============================
	// Addresses
	// ==============================
	assign rom_addr = zx81 ? {1'b0, bus.addr[12:0]}
		: zx81_pkg::ZX80_ROM_BASE + {2'b00, bus.addr[11:0]};

	always_comb begin
		if (ram_lo) begin
			ram_addr = {3'b001, bus.addr[12:0]};
		end else begin
			case (mem_size)
				zx81_pkg::MEM_1K: ram_addr = {6'b010000, bus.addr[9:0]};
				zx81_pkg::MEM_16K: ram_addr = {2'b01, bus.addr[13:0]};
				default: begin
					if (bus.addr[15:14] == 2'b10) begin
						ram_addr = {2'b10, bus.addr[13:0]};
					end else if (bus.addr[15:14] == 2'b11 && mem_48k) begin
						// Opcode fetches still run from the main 16K
						ram_addr = {bus.m1_n, 1'b1, bus.addr[13:0]};
					end else begin
						ram_addr = {2'b01, bus.addr[13:0]};
					end
				end
			endcase
		end
	end

	// ==============================
	// Write enables
	// ==============================
	assign mem_write = ~bus.mreq_n & ~bus.wr_n;
	assign ram_we = mem_write & ram_cs & ~chroma_cs;
	assign chroma_we = mem_write & chroma_cs;

endmodule

//--- verilog/machine_config.sv
// Model and RAM size only take effect under machine_reset; a change stretches reset ~1M cycles
`timescale 1ns/1ps

module machine_config (
	input  logic                clk_sys,
	input  logic                reset,
	input  logic                cfg_zx80,
	input  zx81_pkg::mem_size_e cfg_ram,
	output logic                zx81,
	output zx81_pkg::mem_size_e mem_size,
	output logic                machine_reset
);

	logic [31:0] hold_cnt;
	logic cfg_differs;

	assign cfg_differs = (zx81 != ~cfg_zx80) || (mem_size != cfg_ram);

	always_ff @(posedge clk_sys) begin
		machine_reset <= reset | (hold_cnt != '0);

		// Latch follows the inputs for as long as the machine is held
		if (machine_reset) begin
			zx81 <= ~cfg_zx80;
			mem_size <= cfg_ram;
		end

		if (reset) begin
			hold_cnt <= '0;
		end else if (cfg_differs) begin
			hold_cnt <= zx81_pkg::RECONFIG_HOLD;
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - 32'd1;
		end
	end

	// ==============================
	// Checks
	// ==============================

	// A new model or RAM size always holds the machine two cycles later
	a_cfg_reset: assert property (
		@(posedge clk_sys) disable iff (reset)
		$past(cfg_differs && !reset, 2) |-> machine_reset
	);

endmodule

//--- verilog/cpu_bus_if.sv
// Z80 bus snapshot for the decoders; no handshake, strobes are active low and unregistered
`timescale 1ns/1ps

interface cpu_bus_if;

	zx81_pkg::addr_t addr;
	// Data driven by the CPU on writes
	zx81_pkg::byte_t dout;
	logic mreq_n;
	logic iorq_n;
	logic rd_n;
	logic wr_n;
	logic m1_n;
	logic halt_n;

	// Every block only observes the bus
	modport decoder (
		input addr,
		input dout,
		input mreq_n,
		input iorq_n,
		input rd_n,
		input wr_n,
		input m1_n,
		input halt_n
	);

endinterface

//--- verilog/zx81_pkg.sv
// Shared bus types and constants; one clk_sys domain, all CPU strobes active low
package zx81_pkg;

	// ==============================
	// Bus and memory types
	// ==============================
	typedef logic [15:0] addr_t;
	typedef logic [7:0] byte_t;
	typedef logic [15:0] ram_addr_t;
	// ZX81 image at 0000h, ZX80 image at 2000h
	typedef logic [13:0] rom_addr_t;

	typedef enum logic [1:0] {
		MEM_1K  = 2'd0,
		MEM_16K = 2'd1,
		MEM_32K = 2'd2,
		MEM_48K = 2'd3
	} mem_size_e;

	// Bit 0 right, 1 left, 2 down, 3 up, 4 fire
	typedef logic [4:0] joy_t;
	// Active low, one bit per key in the row
	typedef logic [4:0] key_row_t;

	// ==============================
	// Constants
	// ==============================
	localparam addr_t ZXPAND_PORT = 16'hE007;
	localparam addr_t CHROMA_PORT = 16'h7FEF;
	localparam byte_t CHROMA_ID = 8'hDF;

	// ZXpand joystick port commands
	localparam byte_t ZXP_CMD_HIGH = 8'hAA;
	localparam byte_t ZXP_CMD_LOW = 8'h55;
	localparam byte_t ZXP_CMD_JOY = 8'hA0;

	// Idle data bus and the forced opcode of the display fetch
	localparam byte_t BUS_FLOAT = 8'hFF;
	localparam byte_t Z80_NOP = 8'h00;

	// Reset stretch after model or RAM size change
	localparam logic [31:0] RECONFIG_HOLD = 32'd1_000_000;
	localparam rom_addr_t ZX80_ROM_BASE = 14'h2000;

endpackage
